/* mesh_router.f */
+incdir+logic
logic/noc_link_pkg.sv
logic/noc_route_pkg.sv
logic/packet_serializer.sv
logic/input_port.sv
logic/output_arbiter.sv
logic/switch_matrix.sv
logic/mesh_router.sv
bench/mesh_router_properties.sv
bench/mesh_router_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the router testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert \
	--top-module mesh_router_tb \
	-f mesh_router.f \
	-o mesh_router_tb
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "verilator build failed with status $build_status"
	exit 1
fi

./obj_dir/mesh_router_tb +verilator+error+limit+1000 > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "Simulation failed" "$log"; then
	echo "failures reported in $log"
	exit 1
fi

echo "no failures reported in $log"
exit 0

/* bench/mesh_router_tb.sv */
`include "noc_settings.svh"

module mesh_router_tb;
	import noc_link_pkg::*;
	import noc_route_pkg::*;

	localparam int pkt_w = `NOC_FLIT_W * `NOC_PKT_FLITS;
	localparam int pkts_per_src = 6;
	localparam int num_pkts = pkts_per_src * num_ports;
	localparam int cycle_limit = num_pkts * `NOC_PKT_FLITS * num_ports * 4 + 200;
	localparam logic [`NOC_COORD_W-1:0] node_x = 2'd1;
	localparam logic [`NOC_COORD_W-1:0] node_y = 2'd1;

	logic clk;
	logic arst_n;
	logic pkt_valid;
	logic [pkt_w-1:0] pkt_data;
	logic pkt_credit;
	link_t in_flits;
	credit_vec_t credit_out;
	link_t out_flits;
	credit_vec_t credit_in;

	logic [31:0] rng = 32'h007e_0108;
	int cycle = 0;
	int errors = 0;
	int delivered = 0;
	int pkt_credits_back = 0;

	logic [pkt_w-1:0] exp_pkt [num_ports][$]; // per source, in source order
	int exp_head_cyc [num_ports][$]; // cycle the router took the head
	int last_done [num_ports] = '{default: -1};
	int sent_pkts [num_ports] = '{default: 0};
	int flits_left [num_ports] = '{default: 0};
	logic [pkt_w-1:0] cur_pkt [num_ports];
	int tx_credit [num_ports]; // index 0 counts packet credits
	int rx_owed [num_ports] = '{default: 0};
	int stall [num_ports] = '{default: 0};
	logic [pkt_w-1:0] rx_shift [num_ports];
	int rx_cnt [num_ports] = '{default: 0};
	int prev_src [num_ports] = '{default: -1}; // source of the last packet per output
	int prev_end [num_ports] = '{default: 0};

	mesh_router
	#(
		.X_COORD(node_x),
		.Y_COORD(node_y)
	)
	uut
	(
		.clk(clk),
		.arst_n(arst_n),
		.pkt_valid(pkt_valid),
		.pkt_data(pkt_data),
		.pkt_credit(pkt_credit),
		.in_flits(in_flits),
		.credit_out(credit_out),
		.out_flits(out_flits),
		.credit_in(credit_in)
	);

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// xy order seen from this node
	function automatic int expected_port(input logic [pkt_w-1:0] pkt);
		head_t h;
		h = head_t'(pkt[pkt_w-1 -: `NOC_FLIT_W]);
		if (h.dst_x > node_x)
			return int'(port_east);
		if (h.dst_x < node_x)
			return int'(port_west);
		if (h.dst_y > node_y)
			return int'(port_north);
		if (h.dst_y < node_y)
			return int'(port_south);
		return int'(port_local);
	endfunction

	// destination, source tag, payload
	function automatic logic [pkt_w-1:0] new_packet(input int src);
		logic [31:0] r;
		r = next_rand();
		return {r[31:28], 4'(src), r[23:0]};
	endfunction

	function automatic logic owed_any();
		for (int p = 0; p < num_ports; p++)
			if (rx_owed[p] != 0)
				return 1'b1;
		return 1'b0;
	endfunction

	task automatic flag_error(input string msg);
		errors++;
		$display("** Error @ %0t: %s", $time, msg);
	endtask

	task automatic record_sent(input int src, input logic [pkt_w-1:0] pkt);
		exp_pkt[src].push_back(pkt);
		exp_head_cyc[src].push_back(cycle + 1);
		sent_pkts[src]++;
	endtask

	task automatic check_packet(input int o, input logic [pkt_w-1:0] pkt);
		int src;
		int head_cyc;
		logic [pkt_w-1:0] want;
		src = int'(pkt[pkt_w-`NOC_FLIT_W-1 -: `NOC_FLIT_W]);
		if (src >= num_ports || exp_pkt[src].size() == 0)
		begin
			flag_error($sformatf("output %0d sent unknown packet %h", o, pkt));
			return;
		end
		want = exp_pkt[src].pop_front();
		head_cyc = exp_head_cyc[src].pop_front();
		if (pkt != want)
			flag_error($sformatf("output %0d sent %h, expected %h", o, pkt, want));
		if (o != expected_port(want))
			flag_error($sformatf("packet %h left on port %0d, expected port %0d",
				want, o, expected_port(want)));
		// a neighbour whose head was up front when the output unlocked must win first
		if (prev_src[o] == src)
		begin
			for (int t = 1; t < num_ports; t++)
			begin
				if (t != src && exp_pkt[t].size() > 0 && expected_port(exp_pkt[t][0]) == o
					&& exp_head_cyc[t][0] < prev_end[o] && last_done[t] < prev_end[o])
					flag_error($sformatf("output %0d served source %0d twice, source %0d waiting",
						o, src, t));
			end
		end
		prev_src[o] = src;
		prev_end[o] = cycle;
		last_done[src] = cycle;
		delivered++;
	endtask

	task automatic collect();
		for (int p = 0; p < num_ports; p++)
		begin
			if (credit_out[p])
				tx_credit[p]++;
			if (out_flits[p].valid)
			begin
				rx_owed[p]++;
				rx_shift[p] = {rx_shift[p][pkt_w-`NOC_FLIT_W-1:0], out_flits[p].data};
				rx_cnt[p]++;
				if (rx_cnt[p] == `NOC_PKT_FLITS)
				begin
					rx_cnt[p] = 0;
					check_packet(p, rx_shift[p]);
				end
			end
		end
		if (pkt_credit)
		begin
			tx_credit[0]++;
			pkt_credits_back++;
		end
	endtask

	task automatic drive();
		logic [31:0] r;
		pkt_valid = 1'b0;
		in_flits = '0;
		credit_in = '0;
		r = next_rand();
		if (sent_pkts[0] < pkts_per_src && tx_credit[0] > 0 && r[0])
		begin
			pkt_data = new_packet(0);
			if (sent_pkts[0] == 0)
				pkt_data[pkt_w-1 -: `NOC_FLIT_W] = {node_x, node_y}; // first one stays here
			pkt_valid = 1'b1;
			tx_credit[0]--;
			record_sent(0, pkt_data);
		end
		for (int p = 1; p < num_ports; p++)
		begin
			r = next_rand();
			if (flits_left[p] == 0 && sent_pkts[p] < pkts_per_src && tx_credit[p] > 0
				&& r[1:0] != 2'd0)
			begin
				cur_pkt[p] = new_packet(p);
				flits_left[p] = `NOC_PKT_FLITS;
				record_sent(p, cur_pkt[p]); // head goes out right below
			end
			if (flits_left[p] > 0 && tx_credit[p] > 0)
			begin
				in_flits[p].valid = 1'b1;
				in_flits[p].head = (flits_left[p] == `NOC_PKT_FLITS);
				in_flits[p].data = cur_pkt[p][pkt_w-1 -: `NOC_FLIT_W];
				cur_pkt[p] = cur_pkt[p] << `NOC_FLIT_W;
				flits_left[p]--;
				tx_credit[p]--;
			end
		end
		// sinks pay credits back late, with the odd long stall
		for (int p = 0; p < num_ports; p++)
		begin
			r = next_rand();
			if (stall[p] > 0)
				stall[p]--;
			else if (r[4:0] == 5'd0)
				stall[p] = 6 + int'(r[8:5]);
			else if (rx_owed[p] > 0 && r[9])
			begin
				credit_in[p] = 1'b1;
				rx_owed[p]--;
			end
		end
	endtask

	task automatic step();
		@(posedge clk);
		cycle++;
		#1;
		collect();
		drive();
	endtask

	task automatic final_checks();
		for (int p = 0; p < num_ports; p++)
		begin
			if (rx_cnt[p] != 0)
				flag_error($sformatf("output %0d stopped inside a packet", p));
			if (p != 0 && tx_credit[p] != `NOC_BUF_DEPTH)
				flag_error($sformatf("input %0d credit balance %0d, expected %0d",
					p, tx_credit[p], `NOC_BUF_DEPTH));
		end
		if (pkt_credits_back != pkts_per_src)
			flag_error($sformatf("%0d packet credits back, expected %0d",
				pkt_credits_back, pkts_per_src));
	endtask

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(negedge clk)
	begin
		if (cycle >= cycle_limit)
		begin
			$display("timeout: only %0d of %0d packets came out within %0d cycles",
				delivered, num_pkts, cycle_limit);
			$display("Simulation failed");
			$finish;
		end
	end

	initial
	begin
		arst_n = 1'b0;
		pkt_valid = 1'b0;
		pkt_data = '0;
		in_flits = '0;
		credit_in = '0;
		for (int p = 0; p < num_ports; p++)
			tx_credit[p] = (p == 0) ? 1 : `NOC_BUF_DEPTH;
		repeat (2) @(posedge clk);
		#1 arst_n = 1'b1;
		while (delivered < num_pkts || owed_any())
			step();
		repeat (4)
			step(); // last credit pulses
		final_checks();
		$display("%0d packets delivered, %0d scoreboard errors, %0d assertion errors",
			delivered, errors, uut.u_props.err_cnt);
		if (errors == 0 && uut.u_props.err_cnt == 0)
		begin
			$display("Simulation passed");
		end
		else
		begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* bench/mesh_router_properties.sv */
`include "noc_settings.svh"

module mesh_router_properties
#(
	parameter logic [`NOC_COORD_W-1:0] X_COORD = '0,
	parameter logic [`NOC_COORD_W-1:0] Y_COORD = '0
)
(
	input logic clk,
	input logic arst_n,
	input logic pkt_valid,
	input logic pkt_credit,
	input noc_link_pkg::link_t in_flits,
	input noc_link_pkg::credit_vec_t credit_out,
	input noc_link_pkg::link_t out_flits,
	input noc_link_pkg::credit_vec_t credit_in
);
	import noc_link_pkg::*;
	import noc_route_pkg::*;

	int err_cnt = 0;
	logic started; // some packet or flit has come in
	logic [num_ports-1:0] in_valid;
	logic [num_ports-1:0] out_valid;
	logic [num_ports-1:0] out_head;

	// port a head must leave by, x first
	function automatic port_e route_of(input logic [`NOC_FLIT_W-1:0] data);
		head_t h;
		h = head_t'(data);
		if (h.dst_x != X_COORD)
			return (h.dst_x > X_COORD) ? port_east : port_west;
		if (h.dst_y != Y_COORD)
			return (h.dst_y > Y_COORD) ? port_north : port_south;
		return port_local;
	endfunction

	always_comb
	begin
		for (int p = 0; p < num_ports; p++)
		begin
			in_valid[p] = (p != 0) && in_flits[p].valid; // local entry is no real link
			out_valid[p] = out_flits[p].valid;
			out_head[p] = out_flits[p].valid && out_flits[p].head;
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			started <= 1'b0;
		else if (pkt_valid || in_valid != '0)
			started <= 1'b1;
	end

	a_quiet: assert property (@(posedge clk) disable iff (!arst_n)
		!started |-> (out_valid == '0 && credit_out == '0 && !pkt_credit))
	else
	begin
		err_cnt++;
		$error("router output active before any input");
	end

	for (genvar p = 0; p < num_ports; p++)
	begin : g_port
		flit_cnt_t pos; // flits of the current packet seen on this output
		int in_flight; // sent downstream, credit still out

		always_ff @(posedge clk or negedge arst_n)
		begin
			if (!arst_n)
			begin
				pos <= '0;
				in_flight <= 0;
			end
			else
			begin
				if (out_valid[p])
					pos <= pos + 1'b1;
				in_flight <= in_flight + int'(out_valid[p]) - int'(credit_in[p]);
			end
		end

		a_xy_route: assert property (@(posedge clk) disable iff (!arst_n)
			out_head[p] |-> route_of(out_flits[p].data) == port_e'(p))
		else
		begin
			err_cnt++;
			$error("head flit on port %0d has a destination of another port", p);
		end

		a_wormhole: assert property (@(posedge clk) disable iff (!arst_n)
			out_valid[p] |-> (out_flits[p].head == (pos == '0)))
		else
		begin
			err_cnt++;
			$error("packet on port %0d does not have one head and seven body flits", p);
		end

		a_credit_limit: assert property (@(posedge clk) disable iff (!arst_n)
			out_valid[p] |-> in_flight < `NOC_BUF_DEPTH)
		else
		begin
			err_cnt++;
			$error("port %0d sent a flit without a credit", p);
		end

		// credits of the local input go to the serializer
		if (p != 0)
		begin : g_link
			int held; // accepted on this input, credit not yet back

			always_ff @(posedge clk or negedge arst_n)
			begin
				if (!arst_n)
					held <= 0;
				else
					held <= held + int'(in_valid[p]) - int'(credit_out[p]);
			end

			a_credit_back: assert property (@(posedge clk) disable iff (!arst_n)
				credit_out[p] |-> held > 0)
			else
			begin
				err_cnt++;
				$error("input %0d returned a credit for no flit", p);
			end
		end
	end

endmodule

bind mesh_router mesh_router_properties
#(
	.X_COORD(X_COORD),
	.Y_COORD(Y_COORD)
)
u_props
(
	.clk(clk),
	.arst_n(arst_n),
	.pkt_valid(pkt_valid),
	.pkt_credit(pkt_credit),
	.in_flits(in_flits),
	.credit_out(credit_out),
	.out_flits(out_flits),
	.credit_in(credit_in)
);

/* logic/mesh_router.sv */
`include "noc_settings.svh"

module mesh_router
#(
	parameter logic [`NOC_COORD_W-1:0] X_COORD = '0,
	parameter logic [`NOC_COORD_W-1:0] Y_COORD = '0
)
(
	input logic clk,
	input logic arst_n,
	input logic pkt_valid,
	input logic [`NOC_FLIT_W*`NOC_PKT_FLITS-1:0] pkt_data,
	output logic pkt_credit,
	input noc_link_pkg::link_t in_flits,
	output noc_link_pkg::credit_vec_t credit_out,
	output noc_link_pkg::link_t out_flits,
	input noc_link_pkg::credit_vec_t credit_in
);
	import noc_link_pkg::*;
	import noc_route_pkg::*;

	flit_t local_flit;
	link_t port_in;
	link_t port_front; // front flit of every input buffer
	credit_vec_t port_credit;
	credit_vec_t grant_any;
	logic [num_ports-1:0] port_pop;
	port_mask_t port_req [num_ports]; // indexed by input
	port_mask_t arb_req [num_ports]; // indexed by output
	port_mask_t arb_grant [num_ports];
	port_e arb_sel [num_ports];

	packet_serializer u_ser
	(
		.clk(clk),
		.arst_n(arst_n),
		.pkt_valid(pkt_valid),
		.pkt_data(pkt_data),
		.pkt_credit(pkt_credit),
		.flit_out(local_flit),
		.buf_credit(port_credit[port_local])
	);

	// local input comes from the serializer, the local in_flits entry is ignored
	always_comb
	begin
		port_in = in_flits;
		port_in[port_local] = local_flit;
	end

	always_comb
	begin
		credit_out = port_credit;
		credit_out[port_local] = 1'b0; // local credits stay inside, at the serializer
	end

	// requests per input become requests per output, grants fold back into pops
	always_comb
	begin
		port_pop = '0;
		for (int o = 0; o < num_ports; o++)
		begin
			grant_any[o] = |arb_grant[o];
			for (int i = 0; i < num_ports; i++)
			begin
				arb_req[o][i] = port_req[i][o];
				port_pop[i] = port_pop[i] | arb_grant[o][i];
			end
		end
	end

	for (genvar p = 0; p < num_ports; p++)
	begin : g_port
		input_port u_in
		(
			.clk(clk),
			.arst_n(arst_n),
			.x_coord(X_COORD),
			.y_coord(Y_COORD),
			.flit_in(port_in[p]),
			.pop(port_pop[p]),
			.head_flit(port_front[p]),
			.request(port_req[p]),
			.credit_out(port_credit[p])
		);

		output_arbiter u_arb
		(
			.clk(clk),
			.arst_n(arst_n),
			.request(arb_req[p]),
			.credit_in(credit_in[p]),
			.grant(arb_grant[p]),
			.select(arb_sel[p])
		);
	end

	switch_matrix u_xbar
	(
		.clk(clk),
		.arst_n(arst_n),
		.in_flits(port_front),
		.select(arb_sel),
		.grant_any(grant_any),
		.out_flits(out_flits)
	);

endmodule

/* logic/switch_matrix.sv */
module switch_matrix
(
	input logic clk,
	input logic arst_n,
	input noc_link_pkg::link_t in_flits,
	input noc_route_pkg::port_e select [noc_link_pkg::num_ports],
	input noc_link_pkg::credit_vec_t grant_any,
	output noc_link_pkg::link_t out_flits
);
	import noc_link_pkg::*;

	// one output register per port
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			out_flits <= '0;
		else
		begin
			for (int o = 0; o < num_ports; o++)
			begin
				if (grant_any[o])
					out_flits[o] <= in_flits[select[o]];
				else
					out_flits[o].valid <= 1'b0; // old data stays, only valid drops
			end
		end
	end

endmodule

/* logic/output_arbiter.sv */
`include "noc_settings.svh"

module output_arbiter
(
	input logic clk,
	input logic arst_n,
	input noc_route_pkg::port_mask_t request,
	input logic credit_in,
	output noc_route_pkg::port_mask_t grant,
	output noc_route_pkg::port_e select
);
	import noc_link_pkg::*;
	import noc_route_pkg::*;

	localparam int n_req = $bits(port_mask_t);

	wormhole_e state;
	port_e owner; // last winner, holds the output while locked
	port_e winner;
	logic found;
	flit_cnt_t grant_cnt;
	credit_cnt_t credit_q; // free slots downstream
	logic can_send;

	assign can_send = (credit_q != '0);

	// search starts just after the previous winner
	always_comb
	begin
		int idx;
		winner = owner;
		found = 1'b0;
		for (int i = 1; i <= n_req; i++)
		begin
			idx = (int'(owner) + i) % n_req;
			if (!found && request[idx])
			begin
				winner = port_e'(idx);
				found = 1'b1;
			end
		end
	end

	always_comb
	begin
		grant = '0;
		select = winner;
		if (state == forwarding)
		begin
			select = owner;
			if (can_send && request[owner])
				grant[owner] = 1'b1;
		end
		else if (can_send && found)
			grant[winner] = 1'b1;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= idle;
			owner <= port_west; // so local comes first after reset
			grant_cnt <= '0;
			credit_q <= credit_cnt_t'(`NOC_BUF_DEPTH);
		end
		else
		begin
			credit_q <= credit_q - credit_cnt_t'(|grant) + credit_cnt_t'(credit_in);
			if (|grant)
			begin
				if (state == idle)
				begin
					owner <= winner;
					grant_cnt <= flit_cnt_t'(1);
					state <= forwarding;
				end
				else if (grant_cnt == flit_cnt_t'(`NOC_PKT_FLITS-1))
				begin
					grant_cnt <= '0;
					state <= idle; // tail granted, unlock
				end
				else
					grant_cnt <= grant_cnt + 1'b1;
			end
		end
	end

endmodule

/* logic/input_port.sv */
`include "noc_settings.svh"

module input_port
(
	input logic clk,
	input logic arst_n,
	input logic [`NOC_COORD_W-1:0] x_coord,
	input logic [`NOC_COORD_W-1:0] y_coord,
	input noc_link_pkg::flit_t flit_in,
	input logic pop,
	output noc_link_pkg::flit_t head_flit,
	output noc_route_pkg::port_mask_t request,
	output logic credit_out
);
	import noc_link_pkg::*;
	import noc_route_pkg::*;

	localparam int ptr_w = $clog2(`NOC_BUF_DEPTH);

	typedef logic [ptr_w:0] count_t;

	flit_t mem [`NOC_BUF_DEPTH];
	logic [ptr_w-1:0] wr_ptr; // depth is a power of two, pointers wrap by themselves
	logic [ptr_w-1:0] rd_ptr;
	count_t count;
	logic front_valid;
	wormhole_e state;
	wormhole_e phase;
	flit_cnt_t pop_cnt;
	head_t dest;
	port_e route_port;
	port_mask_t held_mask; // route of the packet in flight

	assign front_valid = (count != '0);

	always_comb
	begin
		head_flit = mem[rd_ptr];
		head_flit.valid = front_valid;
	end

	assign dest = head_t'(head_flit.data);

	// x first, then y
	always_comb
	begin
		if (dest.dst_x > x_coord)
			route_port = port_east;
		else if (dest.dst_x < x_coord)
			route_port = port_west;
		else if (dest.dst_y > y_coord)
			route_port = port_north;
		else if (dest.dst_y < y_coord)
			route_port = port_south;
		else
			route_port = port_local;
	end

	always_comb
	begin
		if (state == forwarding)
			phase = forwarding;
		else if (front_valid && head_flit.head)
			phase = routing;
		else
			phase = idle;
	end

	always_comb
	begin
		case (phase)
			routing: request = port_mask_t'(1) << route_port;
			forwarding: request = front_valid ? held_mask : '0; // body flit may still be in flight
			default: request = '0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			state <= idle;
			pop_cnt <= '0;
			held_mask <= '0;
			credit_out <= 1'b0;
		end
		else
		begin
			credit_out <= pop; // one slot freed, one credit back
			if (flit_in.valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + count_t'(flit_in.valid) - count_t'(pop);
			if (pop)
			begin
				if (phase == routing)
				begin
					held_mask <= request;
					pop_cnt <= flit_cnt_t'(1);
					state <= forwarding;
				end
				else if (pop_cnt == flit_cnt_t'(`NOC_PKT_FLITS-1))
				begin
					pop_cnt <= '0;
					state <= idle; // tail gone
				end
				else
					pop_cnt <= pop_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (flit_in.valid)
			mem[wr_ptr] <= flit_in;
	end

endmodule

/* logic/packet_serializer.sv */
`include "noc_settings.svh"

module packet_serializer
(
	input logic clk,
	input logic arst_n,
	input logic pkt_valid,
	input logic [`NOC_FLIT_W*`NOC_PKT_FLITS-1:0] pkt_data,
	output logic pkt_credit,
	output noc_link_pkg::flit_t flit_out,
	input logic buf_credit
);
	import noc_link_pkg::*;

	logic [`NOC_FLIT_W*`NOC_PKT_FLITS-1:0] shift_q; // msb nibble goes out next
	flit_cnt_t idx_q;
	credit_cnt_t credit_q; // free slots in the local input buffer
	logic busy_q;
	logic send;
	logic last;

	assign send = busy_q && (credit_q != '0);
	assign last = (idx_q == flit_cnt_t'(`NOC_PKT_FLITS-1));

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			busy_q <= 1'b0;
			idx_q <= '0;
			credit_q <= credit_cnt_t'(`NOC_BUF_DEPTH);
			flit_out <= '0;
			pkt_credit <= 1'b0;
		end
		else
		begin
			credit_q <= credit_q - credit_cnt_t'(send) + credit_cnt_t'(buf_credit);
			pkt_credit <= send && last; // source may load again once the tail is out
			flit_out.valid <= send;
			flit_out.head <= send && (idx_q == '0);
			flit_out.data <= shift_q[$bits(shift_q)-1 -: `NOC_FLIT_W];
			if (send)
			begin
				if (last)
				begin
					idx_q <= '0;
					busy_q <= 1'b0;
				end
				else
					idx_q <= idx_q + 1'b1;
			end
			else if (!busy_q && pkt_valid)
				busy_q <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!busy_q && pkt_valid)
			shift_q <= pkt_data;
		else if (send)
			shift_q <= shift_q << `NOC_FLIT_W;
	end

endmodule

/* logic/noc_route_pkg.sv */
`include "noc_settings.svh"

package noc_route_pkg;

	typedef enum logic [2:0]
	{
		port_local = 3'd0,
		port_north = 3'd1,
		port_south = 3'd2,
		port_east = 3'd3,
		port_west = 3'd4
	} port_e;

	// one bit per port, one-hot for requests and grants
	typedef logic [port_west:0] port_mask_t;

	// data field of a head flit
	typedef struct packed
	{
		logic [`NOC_COORD_W-1:0] dst_x;
		logic [`NOC_COORD_W-1:0] dst_y;
	} head_t;

	typedef enum logic [1:0]
	{
		idle,
		routing, // head at the front, route known, not yet granted
		forwarding
	} wormhole_e;

endpackage

/* logic/noc_link_pkg.sv */
`include "noc_settings.svh"

package noc_link_pkg;

	localparam int num_ports = 5; // local plus four neighbours

	// one flit on a link, valid for a single cycle
	typedef struct packed
	{
		logic valid;
		logic head; // first flit of a packet
		logic [`NOC_FLIT_W-1:0] data;
	} flit_t;

	// all flits of one router side, indexed by port
	typedef flit_t [num_ports-1:0] link_t;

	// one credit pulse per port
	typedef logic [num_ports-1:0] credit_vec_t;

	// free slots of a downstream buffer, 0 .. NOC_BUF_DEPTH
	typedef logic [$clog2(`NOC_BUF_DEPTH+1)-1:0] credit_cnt_t;

	// position of a flit inside its packet
	typedef logic [$clog2(`NOC_PKT_FLITS)-1:0] flit_cnt_t;

endpackage

/* logic/noc_settings.svh */
`ifndef NOC_SETTINGS_SVH
`define NOC_SETTINGS_SVH

// bits carried by one flit
`define NOC_FLIT_W 4

// a 32-bit packet travels as this many flits
`define NOC_PKT_FLITS 8

// flit slots in every input buffer, also the credit count per output
`define NOC_BUF_DEPTH 4

// width of one mesh coordinate
`define NOC_COORD_W 2

`endif
